//--- common/lcarb_pkg.sv
// Shared widths, register map and enums for the DMA command arbiter, imported by every RTL block
`default_nettype none

package lcarb_pkg;

    // --------------------
    // Command fields
    localparam int LCADDR_W = 32;
    localparam int RTADDR_W = 32;
    localparam int SIZE_W   = 20;
    localparam int DEST_W   = 2;
    localparam int HPU_ID_W = 4;
    localparam int OP_W     = 2;

    // --------------------
    // Control bus
    localparam int CSR_DATA_W = 32;
    localparam int CSR_ADDR_W = 8;

    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_CTRL   = 8'h00;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_STATUS = 8'h04;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_LCADDR = 8'h08;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_RTADDR = 8'h0c;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_SIZE   = 8'h10;
    localparam logic [CSR_ADDR_W-1:0] CSR_ADDR_DESTXY = 8'h14;

    // --------------------
    // Completion slots and transfer ID
    localparam int SLOT_COUNT = 8;
    localparam int SLOT_IDX_W = 3;

    // The ID holds class, slot index, opcode and issuing node from the top bit down
    localparam int NDMA_ID_W   = 1 + SLOT_IDX_W + OP_W + HPU_ID_W;
    localparam int ID_CLS_POS  = NDMA_ID_W - 1;
    localparam int ID_SLOT_LSB = OP_W + HPU_ID_W;
    localparam int ID_OP_LSB   = HPU_ID_W;

    // Queue entry is the ID followed by the command fields
    localparam int CMD_W = NDMA_ID_W + OP_W + LCADDR_W + RTADDR_W + SIZE_W + 2 * DEST_W;

    typedef enum logic [OP_W-1:0] {
        OP_WRITE = 2'd0,
        OP_READ  = 2'd1,
        OP_SWAP  = 2'd2,
        // Only meaningful in the control register
        OP_CLEAR = 2'd3
    } ndma_op_e;

    typedef enum logic {
        ARB_L2C = 1'b0,
        ARB_CSR = 1'b1
    } arb_state_e;

endpackage

`default_nettype wire

//--- source/ndma_ctrl_regs.sv
// Control registers that stage a software DMA command, issue done-clear pulses and serve reads
`default_nettype none

module ndma_ctrl_regs
    import lcarb_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire logic                  csr_wr_en_i,
    input  wire logic [CSR_ADDR_W-1:0] csr_waddr_i,
    input  wire logic [CSR_DATA_W-1:0] csr_wdata_i,
    input  wire logic [CSR_ADDR_W-1:0] csr_raddr_i,
    output logic      [CSR_DATA_W-1:0] csr_rdata_o,
    input  wire logic [SLOT_COUNT-1:0] done_vec_i,
    input  wire logic [SLOT_IDX_W-1:0] cur_slot_i,
    input  wire logic                  sw_cmd_taken_i,
    output logic                       sw_cmd_pending_o,
    output ndma_op_e                   sw_op_o,
    output logic      [LCADDR_W-1:0]   sw_lcaddr_o,
    output logic      [RTADDR_W-1:0]   sw_rtaddr_o,
    output logic      [SIZE_W-1:0]     sw_size_o,
    output logic      [DEST_W-1:0]     sw_destx_o,
    output logic      [DEST_W-1:0]     sw_desty_o,
    output logic                       done_clr_o,
    output logic      [SLOT_COUNT-1:0] done_clr_mask_o
);

    ndma_op_e ctrl_op;
    logic     ctrl_wr;

    assign ctrl_op = ndma_op_e'(csr_wdata_i[OP_W-1:0]);
    assign ctrl_wr = csr_wr_en_i && (csr_waddr_i == CSR_ADDR_CTRL);

    // --------------------
    // Staged command fields
    always_ff @(posedge clk_i) begin
        if (csr_wr_en_i) begin
            case (csr_waddr_i)
                CSR_ADDR_LCADDR: sw_lcaddr_o <= csr_wdata_i[LCADDR_W-1:0];
                CSR_ADDR_RTADDR: sw_rtaddr_o <= csr_wdata_i[RTADDR_W-1:0];
                CSR_ADDR_SIZE:   sw_size_o <= csr_wdata_i[SIZE_W-1:0];
                CSR_ADDR_DESTXY: {sw_destx_o, sw_desty_o} <= csr_wdata_i[2*DEST_W-1:0];
                default: ;
            endcase
        end
        // A clear leaves the staged opcode alone so a pending command keeps it
        if (ctrl_wr && ctrl_op != OP_CLEAR) begin
            sw_op_o <= ctrl_op;
        end
        if (ctrl_wr && ctrl_op == OP_CLEAR) begin
            done_clr_mask_o <= csr_wdata_i[CSR_DATA_W-1 -: SLOT_COUNT];
        end
    end

    // --------------------
    // Command pending flag and clear pulse
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sw_cmd_pending_o <= 1'b0;
            done_clr_o       <= 1'b0;
        end else begin
            // A new command wins over the handoff of the previous one
            if (ctrl_wr && ctrl_op != OP_CLEAR) begin
                sw_cmd_pending_o <= 1'b1;
            end else if (sw_cmd_taken_i) begin
                sw_cmd_pending_o <= 1'b0;
            end
            done_clr_o <= ctrl_wr && (ctrl_op == OP_CLEAR);
        end
    end

    // --------------------
    // Read data follows the address by one cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            csr_rdata_o <= '0;
        end else begin
            case (csr_raddr_i)
                CSR_ADDR_CTRL:   csr_rdata_o <= {done_clr_mask_o, 22'h0, sw_op_o};
                CSR_ADDR_STATUS: csr_rdata_o <= {done_vec_i, 15'h0, sw_cmd_pending_o,
                                                 5'h0, cur_slot_i};
                CSR_ADDR_LCADDR: csr_rdata_o <= CSR_DATA_W'(sw_lcaddr_o);
                CSR_ADDR_RTADDR: csr_rdata_o <= CSR_DATA_W'(sw_rtaddr_o);
                CSR_ADDR_SIZE:   csr_rdata_o <= CSR_DATA_W'(sw_size_o);
                CSR_ADDR_DESTXY: csr_rdata_o <= CSR_DATA_W'({sw_destx_o, sw_desty_o});
                default:         csr_rdata_o <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/done_slot_tracker.sv
// Decodes DMA completion reports into slot done bits, cache-side done strobes and the interrupt
`default_nettype none

module done_slot_tracker
    import lcarb_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire logic [HPU_ID_W-1:0]   hpu_id_i,
    input  wire logic                  ndma_tx_done_i,
    input  wire logic [NDMA_ID_W-1:0]  ndma_tx_done_id_i,
    input  wire logic                  ndma_rx_done_i,
    input  wire logic [NDMA_ID_W-1:0]  ndma_rx_done_id_i,
    input  wire logic                  slot_take_i,
    input  wire logic                  done_clr_i,
    input  wire logic [SLOT_COUNT-1:0] done_clr_mask_i,
    output logic      [SLOT_IDX_W-1:0] free_slot_o,
    output logic                       slot_avail_o,
    output logic      [SLOT_IDX_W-1:0] cur_slot_o,
    output logic      [SLOT_COUNT-1:0] done_vec_o,
    output logic                       l2c_cmd_done_o,
    output logic                       ndma_intr_o
);

    logic                  tx_q;
    logic                  rx_q;
    logic [NDMA_ID_W-1:0]  tx_id_q;
    logic [NDMA_ID_W-1:0]  rx_id_q;
    ndma_op_e              tx_op;
    ndma_op_e              rx_op;
    logic                  tx_mine;
    logic                  rx_mine;
    logic [SLOT_COUNT-1:0] busy;

    // --------------------
    // Report capture
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tx_q <= 1'b0;
            rx_q <= 1'b0;
        end else begin
            tx_q <= ndma_tx_done_i;
            rx_q <= ndma_rx_done_i;
        end
    end

    always_ff @(posedge clk_i) begin
        tx_id_q <= ndma_tx_done_id_i;
        rx_id_q <= ndma_rx_done_id_i;
    end

    assign tx_op = ndma_op_e'(tx_id_q[ID_OP_LSB +: OP_W]);
    assign rx_op = ndma_op_e'(rx_id_q[ID_OP_LSB +: OP_W]);

    // Writes finish on transmit, reads and swaps on receive
    assign tx_mine = tx_q && (tx_id_q[HPU_ID_W-1:0] == hpu_id_i) && (tx_op == OP_WRITE);
    assign rx_mine = rx_q && (rx_id_q[HPU_ID_W-1:0] == hpu_id_i)
                     && (rx_op == OP_READ || rx_op == OP_SWAP);

    assign l2c_cmd_done_o = (tx_mine && tx_id_q[ID_CLS_POS]) || (rx_mine && rx_id_q[ID_CLS_POS]);

    // --------------------
    // Slot state
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy       <= '0;
            done_vec_o <= '0;
            cur_slot_o <= '0;
        end else begin
            if (slot_take_i) begin
                busy[free_slot_o] <= 1'b1;
                cur_slot_o        <= free_slot_o;
            end
            for (int i = 0; i < SLOT_COUNT; i++) begin
                if (done_clr_i && done_clr_mask_i[i]) begin
                    done_vec_o[i] <= 1'b0;
                end
                // A completion in the same cycle as a clear is kept
                if ((tx_mine && !tx_id_q[ID_CLS_POS]
                     && tx_id_q[ID_SLOT_LSB +: SLOT_IDX_W] == SLOT_IDX_W'(i))
                    || (rx_mine && !rx_id_q[ID_CLS_POS]
                     && rx_id_q[ID_SLOT_LSB +: SLOT_IDX_W] == SLOT_IDX_W'(i))) begin
                    done_vec_o[i] <= 1'b1;
                    busy[i]       <= 1'b0;
                end
            end
        end
    end

    // Lowest slot that is neither in flight nor waiting to be cleared
    always_comb begin
        free_slot_o  = '0;
        slot_avail_o = 1'b0;
        for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
            if (!busy[i] && !done_vec_o[i]) begin
                free_slot_o  = SLOT_IDX_W'(i);
                slot_avail_o = 1'b1;
            end
        end
    end

    assign ndma_intr_o = |done_vec_o;

endmodule

`default_nettype wire

//--- source/cmd_source_arbiter.sv
// Picks between cache-side and software commands, tags them with an ID and writes the queue
`default_nettype none

module cmd_source_arbiter
    import lcarb_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire logic [HPU_ID_W-1:0]   hpu_id_i,
    input  wire logic                  l2c_cmd_valid_i,
    input  wire ndma_op_e              l2c_cmd_op_i,
    input  wire logic [LCADDR_W-1:0]   l2c_cmd_lcaddr_i,
    input  wire logic [RTADDR_W-1:0]   l2c_cmd_rtaddr_i,
    input  wire logic [SIZE_W-1:0]     l2c_cmd_size_i,
    input  wire logic [DEST_W-1:0]     l2c_cmd_destx_i,
    input  wire logic [DEST_W-1:0]     l2c_cmd_desty_i,
    output logic                       l2c_cmd_ready_o,
    input  wire logic                  sw_cmd_pending_i,
    input  wire ndma_op_e              sw_op_i,
    input  wire logic [LCADDR_W-1:0]   sw_lcaddr_i,
    input  wire logic [RTADDR_W-1:0]   sw_rtaddr_i,
    input  wire logic [SIZE_W-1:0]     sw_size_i,
    input  wire logic [DEST_W-1:0]     sw_destx_i,
    input  wire logic [DEST_W-1:0]     sw_desty_i,
    input  wire logic [SLOT_IDX_W-1:0] free_slot_i,
    input  wire logic                  slot_avail_i,
    output logic                       sw_cmd_taken_o,
    input  wire logic                  queue_full_i,
    output logic                       queue_we_o,
    output logic      [CMD_W-1:0]      queue_wdata_o
);

    arb_state_e           state;
    logic [NDMA_ID_W-1:0] l2c_id;
    logic [NDMA_ID_W-1:0] sw_id;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state <= ARB_L2C;
        end else begin
            case (state)
                ARB_L2C: if (sw_cmd_pending_i && slot_avail_i) state <= ARB_CSR;
                ARB_CSR: if (l2c_cmd_valid_i) state <= ARB_L2C;
                default: state <= ARB_L2C;
            endcase
        end
    end

    assign l2c_cmd_ready_o = (state == ARB_L2C) && !queue_full_i;
    assign sw_cmd_taken_o  = (state == ARB_CSR) && !queue_full_i && slot_avail_i
                             && sw_cmd_pending_i;

    // Cache-side commands carry class 1 and slot 0
    assign l2c_id = {1'b1, SLOT_IDX_W'(0), l2c_cmd_op_i, hpu_id_i};
    assign sw_id  = {1'b0, free_slot_i, sw_op_i, hpu_id_i};

    assign queue_we_o = (state == ARB_L2C) ? (l2c_cmd_valid_i && l2c_cmd_ready_o)
                                           : sw_cmd_taken_o;

    assign queue_wdata_o = (state == ARB_L2C)
        ? {l2c_id, l2c_cmd_op_i, l2c_cmd_lcaddr_i, l2c_cmd_rtaddr_i, l2c_cmd_size_i,
           l2c_cmd_destx_i, l2c_cmd_desty_i}
        : {sw_id, sw_op_i, sw_lcaddr_i, sw_rtaddr_i, sw_size_i, sw_destx_i, sw_desty_i};

endmodule

`default_nettype wire

//--- source/cmd_queue.sv
// Two-entry first-word-fall-through queue holding tagged commands for the DMA command port
`default_nettype none

module cmd_queue
    import lcarb_pkg::*;
(
    input  wire logic             clk_i,
    input  wire logic             reset_i,
    input  wire logic             wr_en_i,
    input  wire logic [CMD_W-1:0] wr_data_i,
    output logic                  full_o,
    input  wire logic             rd_en_i,
    output logic      [CMD_W-1:0] rd_data_o,
    output logic                  empty_o
);

    logic [CMD_W-1:0] mem [2];
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count;
    logic             push;
    logic             pop;

    assign push = wr_en_i && !full_o;
    assign pop  = rd_en_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + 2'(push) - 2'(pop);
        end
    end

    assign full_o    = (count == 2'd2);
    assign empty_o   = (count == 2'd0);
    assign rd_data_o = mem[rd_ptr];

endmodule

`default_nettype wire

//--- source/ndma_lcarb.sv
// Top of the DMA command arbiter, joining registers, slot tracker, arbiter and command queue
`default_nettype none

module ndma_lcarb
    import lcarb_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire logic [HPU_ID_W-1:0]   hpu_id_i,
    // Cache-side command port
    input  wire logic                  l2c_cmd_valid_i,
    output logic                       l2c_cmd_ready_o,
    input  wire ndma_op_e              l2c_cmd_op_i,
    input  wire logic [LCADDR_W-1:0]   l2c_cmd_lcaddr_i,
    input  wire logic [RTADDR_W-1:0]   l2c_cmd_rtaddr_i,
    input  wire logic [SIZE_W-1:0]     l2c_cmd_size_i,
    input  wire logic [DEST_W-1:0]     l2c_cmd_destx_i,
    input  wire logic [DEST_W-1:0]     l2c_cmd_desty_i,
    output logic                       l2c_cmd_done_o,
    // DMA command port
    output logic                       ndma_cmd_valid_o,
    input  wire logic                  ndma_cmd_ready_i,
    output ndma_op_e                   ndma_cmd_op_o,
    output logic      [NDMA_ID_W-1:0]  ndma_cmd_id_o,
    output logic      [LCADDR_W-1:0]   ndma_cmd_lcaddr_o,
    output logic      [RTADDR_W-1:0]   ndma_cmd_rtaddr_o,
    output logic      [SIZE_W-1:0]     ndma_cmd_size_o,
    output logic      [DEST_W-1:0]     ndma_cmd_destx_o,
    output logic      [DEST_W-1:0]     ndma_cmd_desty_o,
    // Completion reports
    input  wire logic                  ndma_tx_done_i,
    input  wire logic [NDMA_ID_W-1:0]  ndma_tx_done_id_i,
    input  wire logic                  ndma_rx_done_i,
    input  wire logic [NDMA_ID_W-1:0]  ndma_rx_done_id_i,
    output logic                       ndma_intr_o,
    // Control bus
    input  wire logic                  csr_wr_en_i,
    input  wire logic [CSR_ADDR_W-1:0] csr_waddr_i,
    input  wire logic [CSR_DATA_W-1:0] csr_wdata_i,
    input  wire logic [CSR_ADDR_W-1:0] csr_raddr_i,
    output logic      [CSR_DATA_W-1:0] csr_rdata_o
);

    logic                  sw_cmd_pending;
    logic                  sw_cmd_taken;
    ndma_op_e              sw_op;
    logic [LCADDR_W-1:0]   sw_lcaddr;
    logic [RTADDR_W-1:0]   sw_rtaddr;
    logic [SIZE_W-1:0]     sw_size;
    logic [DEST_W-1:0]     sw_destx;
    logic [DEST_W-1:0]     sw_desty;
    logic                  done_clr;
    logic [SLOT_COUNT-1:0] done_clr_mask;
    logic [SLOT_COUNT-1:0] done_vec;
    logic [SLOT_IDX_W-1:0] cur_slot;
    logic [SLOT_IDX_W-1:0] free_slot;
    logic                  slot_avail;
    logic                  queue_we;
    logic [CMD_W-1:0]      queue_wdata;
    logic                  queue_full;
    logic                  queue_empty;
    logic [CMD_W-1:0]      queue_head;
    logic [OP_W-1:0]       head_op;

    ndma_ctrl_regs u_regs (
        .clk_i, .reset_i, .csr_wr_en_i, .csr_waddr_i, .csr_wdata_i, .csr_raddr_i, .csr_rdata_o,
        .done_vec_i       (done_vec),
        .cur_slot_i       (cur_slot),
        .sw_cmd_taken_i   (sw_cmd_taken),
        .sw_cmd_pending_o (sw_cmd_pending),
        .sw_op_o          (sw_op),
        .sw_lcaddr_o      (sw_lcaddr),
        .sw_rtaddr_o      (sw_rtaddr),
        .sw_size_o        (sw_size),
        .sw_destx_o       (sw_destx),
        .sw_desty_o       (sw_desty),
        .done_clr_o       (done_clr),
        .done_clr_mask_o  (done_clr_mask)
    );

    done_slot_tracker u_tracker (
        .clk_i, .reset_i, .hpu_id_i, .ndma_tx_done_i, .ndma_tx_done_id_i,
        .ndma_rx_done_i, .ndma_rx_done_id_i, .l2c_cmd_done_o, .ndma_intr_o,
        .slot_take_i     (sw_cmd_taken),
        .done_clr_i      (done_clr),
        .done_clr_mask_i (done_clr_mask),
        .free_slot_o     (free_slot),
        .slot_avail_o    (slot_avail),
        .cur_slot_o      (cur_slot),
        .done_vec_o      (done_vec)
    );

    cmd_source_arbiter u_arbiter (
        .clk_i, .reset_i, .hpu_id_i, .l2c_cmd_valid_i, .l2c_cmd_op_i, .l2c_cmd_lcaddr_i,
        .l2c_cmd_rtaddr_i, .l2c_cmd_size_i, .l2c_cmd_destx_i, .l2c_cmd_desty_i, .l2c_cmd_ready_o,
        .sw_cmd_pending_i (sw_cmd_pending),
        .sw_op_i          (sw_op),
        .sw_lcaddr_i      (sw_lcaddr),
        .sw_rtaddr_i      (sw_rtaddr),
        .sw_size_i        (sw_size),
        .sw_destx_i       (sw_destx),
        .sw_desty_i       (sw_desty),
        .free_slot_i      (free_slot),
        .slot_avail_i     (slot_avail),
        .sw_cmd_taken_o   (sw_cmd_taken),
        .queue_full_i     (queue_full),
        .queue_we_o       (queue_we),
        .queue_wdata_o    (queue_wdata)
    );

    cmd_queue u_queue (
        .clk_i, .reset_i,
        .wr_en_i   (queue_we),
        .wr_data_i (queue_wdata),
        .full_o    (queue_full),
        .rd_en_i   (ndma_cmd_valid_o && ndma_cmd_ready_i),
        .rd_data_o (queue_head),
        .empty_o   (queue_empty)
    );

    // --------------------
    // Queue head onto the DMA command port
    assign ndma_cmd_valid_o = !queue_empty;
    assign {ndma_cmd_id_o, head_op, ndma_cmd_lcaddr_o, ndma_cmd_rtaddr_o, ndma_cmd_size_o,
            ndma_cmd_destx_o, ndma_cmd_desty_o} = queue_head;
    assign ndma_cmd_op_o = ndma_op_e'(head_op);

endmodule

`default_nettype wire

//--- verif/tb_ndma_lcarb.sv
// Table-driven testbench for the DMA command arbiter, run as the simulation top with UUT inside
`default_nettype none

module tb_ndma_lcarb
    import lcarb_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [HPU_ID_W-1:0] HPU     = 4'h5;
    localparam int                  TIMEOUT = 50;

    typedef enum logic [3:0] {
        S_WR, S_RD, S_POLL, S_L2C, S_CMD, S_RPT, S_BITS, S_HOLD, S_IDLE
    } step_e;

    // data holds write data, expected read data, a report ID, an expected ID or a cycle count
    typedef struct packed {
        step_e                 kind;
        logic [CSR_ADDR_W-1:0] addr;
        logic [31:0]           data;
        ndma_op_e              op;
        logic [2:0]            idx;
        logic                  flag;
        logic                  exp_a;
        logic                  exp_b;
    } step_t;

    logic                  clk_i;
    logic                  reset_i;
    logic [HPU_ID_W-1:0]   hpu_id_i;
    logic                  l2c_cmd_valid_i;
    logic                  l2c_cmd_ready_o;
    ndma_op_e              l2c_cmd_op_i;
    logic [LCADDR_W-1:0]   l2c_cmd_lcaddr_i;
    logic [RTADDR_W-1:0]   l2c_cmd_rtaddr_i;
    logic [SIZE_W-1:0]     l2c_cmd_size_i;
    logic [DEST_W-1:0]     l2c_cmd_destx_i;
    logic [DEST_W-1:0]     l2c_cmd_desty_i;
    logic                  l2c_cmd_done_o;
    logic                  ndma_cmd_valid_o;
    logic                  ndma_cmd_ready_i;
    ndma_op_e              ndma_cmd_op_o;
    logic [NDMA_ID_W-1:0]  ndma_cmd_id_o;
    logic [LCADDR_W-1:0]   ndma_cmd_lcaddr_o;
    logic [RTADDR_W-1:0]   ndma_cmd_rtaddr_o;
    logic [SIZE_W-1:0]     ndma_cmd_size_o;
    logic [DEST_W-1:0]     ndma_cmd_destx_o;
    logic [DEST_W-1:0]     ndma_cmd_desty_o;
    logic                  ndma_tx_done_i;
    logic [NDMA_ID_W-1:0]  ndma_tx_done_id_i;
    logic                  ndma_rx_done_i;
    logic [NDMA_ID_W-1:0]  ndma_rx_done_id_i;
    logic                  ndma_intr_o;
    logic                  csr_wr_en_i;
    logic [CSR_ADDR_W-1:0] csr_waddr_i;
    logic [CSR_DATA_W-1:0] csr_wdata_i;
    logic [CSR_ADDR_W-1:0] csr_raddr_i;
    logic [CSR_DATA_W-1:0] csr_rdata_o;

    step_t               steps [64];
    string               names [64];
    int                  n_steps;
    int                  errors;
    logic [LCADDR_W-1:0] cmd_lc [6];
    logic [RTADDR_W-1:0] cmd_rt [6];
    logic [SIZE_W-1:0]   cmd_sz [6];
    logic [DEST_W-1:0]   cmd_dx [6];
    logic [DEST_W-1:0]   cmd_dy [6];

    ndma_lcarb UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // --------------------
    // Compare tasks
    task automatic check_word(input string name, input logic [CSR_DATA_W-1:0] exp,
                              input logic [CSR_DATA_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_cmd(input string name, input ndma_op_e op,
                             input logic [NDMA_ID_W-1:0] id, input logic [LCADDR_W-1:0] lc,
                             input logic [RTADDR_W-1:0] rt, input logic [SIZE_W-1:0] sz,
                             input logic [DEST_W-1:0] dx, input logic [DEST_W-1:0] dy);
        if (ndma_cmd_op_o !== op) begin
            errors++;
            $display("FAIL %s op: expected %s, actual %s", name, op.name(), ndma_cmd_op_o.name());
        end
        if (ndma_cmd_id_o !== id) begin
            errors++;
            $display("FAIL %s id: expected %h, actual %h", name, id, ndma_cmd_id_o);
        end
        if ({ndma_cmd_lcaddr_o, ndma_cmd_rtaddr_o, ndma_cmd_size_o, ndma_cmd_destx_o,
             ndma_cmd_desty_o} !== {lc, rt, sz, dx, dy}) begin
            errors++;
            $display("FAIL %s fields: expected %h, actual %h", name, {lc, rt, sz, dx, dy},
                     {ndma_cmd_lcaddr_o, ndma_cmd_rtaddr_o, ndma_cmd_size_o,
                      ndma_cmd_destx_o, ndma_cmd_desty_o});
        end
    endtask

    task automatic report_timeout(input string name, input string what);
        errors++;
        $display("Timeout in step %s while waiting for %s", name, what);
    endtask

    // --------------------
    // Step table
    // Builds a transfer ID from class, slot, opcode and node with the class on top
    function automatic logic [31:0] cmd_id(input logic cls, input logic [2:0] slot,
                                           input ndma_op_e op, input logic [3:0] node);
        return {22'h0, cls, slot, op, node};
    endfunction

    task automatic add_step(input step_e kind, input string name, input logic [7:0] addr,
                            input logic [31:0] data, input ndma_op_e op, input int idx,
                            input logic flag, input logic exp_a, input logic exp_b);
        steps[n_steps] = '{kind, addr, data, op, 3'(idx), flag, exp_a, exp_b};
        names[n_steps] = name;
        n_steps++;
    endtask

    task automatic add_sw_cmd(input string name, input int idx, input ndma_op_e op);
        add_step(S_WR, name, CSR_ADDR_LCADDR, cmd_lc[idx], op, idx, 0, 0, 0);
        add_step(S_WR, name, CSR_ADDR_RTADDR, cmd_rt[idx], op, idx, 0, 0, 0);
        add_step(S_WR, name, CSR_ADDR_SIZE, {12'h0, cmd_sz[idx]}, op, idx, 0, 0, 0);
        add_step(S_WR, name, CSR_ADDR_DESTXY, {28'h0, cmd_dx[idx], cmd_dy[idx]}, op, idx, 0, 0, 0);
        add_step(S_WR, name, CSR_ADDR_CTRL, {30'h0, op}, op, idx, 0, 0, 0);
    endtask

    // --------------------
    // Each step starts and ends on a falling edge
    task automatic run_step(input int s);
        step_t st;
        int    wait_n;
        st = steps[s];
        wait_n = 0;
        case (st.kind)
            S_WR: begin
                csr_wr_en_i = 1'b1;
                csr_waddr_i = st.addr;
                csr_wdata_i = st.data;
                @(negedge clk_i);
                csr_wr_en_i = 1'b0;
            end
            S_RD: begin
                csr_raddr_i = st.addr;
                @(negedge clk_i);
                check_word(names[s], st.data, csr_rdata_o);
            end
            S_POLL: begin
                csr_raddr_i = st.addr;
                @(negedge clk_i);
                while (csr_rdata_o !== st.data && wait_n < TIMEOUT) begin
                    @(negedge clk_i);
                    wait_n++;
                end
                if (csr_rdata_o !== st.data) report_timeout(names[s], "the register value");
            end
            S_L2C: begin
                l2c_cmd_valid_i  = 1'b1;
                l2c_cmd_op_i     = st.op;
                l2c_cmd_lcaddr_i = cmd_lc[st.idx];
                l2c_cmd_rtaddr_i = cmd_rt[st.idx];
                l2c_cmd_size_i   = cmd_sz[st.idx];
                l2c_cmd_destx_i  = cmd_dx[st.idx];
                l2c_cmd_desty_i  = cmd_dy[st.idx];
                while (!l2c_cmd_ready_o && wait_n < TIMEOUT) begin
                    @(negedge clk_i);
                    wait_n++;
                end
                if (!l2c_cmd_ready_o) report_timeout(names[s], "cache-side ready");
                // Ready is seen here, so the next rising edge takes the command
                @(negedge clk_i);
                l2c_cmd_valid_i = 1'b0;
            end
            S_CMD: begin
                while (!ndma_cmd_valid_o && wait_n < TIMEOUT) begin
                    @(negedge clk_i);
                    wait_n++;
                end
                if (!ndma_cmd_valid_o) begin
                    report_timeout(names[s], "a command at the DMA port");
                end else begin
                    check_cmd(names[s], st.op, st.data[NDMA_ID_W-1:0], cmd_lc[st.idx],
                              cmd_rt[st.idx], cmd_sz[st.idx], cmd_dx[st.idx], cmd_dy[st.idx]);
                    if (st.flag) begin
                        ndma_cmd_ready_i = 1'b1;
                        @(negedge clk_i);
                        ndma_cmd_ready_i = 1'b0;
                    end
                end
            end
            S_RPT: begin
                if (st.flag) begin
                    ndma_rx_done_i    = 1'b1;
                    ndma_rx_done_id_i = st.data[NDMA_ID_W-1:0];
                end else begin
                    ndma_tx_done_i    = 1'b1;
                    ndma_tx_done_id_i = st.data[NDMA_ID_W-1:0];
                end
                @(negedge clk_i);
                ndma_tx_done_i = 1'b0;
                ndma_rx_done_i = 1'b0;
                check_bit({names[s], " done strobe"}, st.exp_a, l2c_cmd_done_o);
                @(negedge clk_i);
                check_bit({names[s], " done strobe end"}, 1'b0, l2c_cmd_done_o);
                check_bit({names[s], " interrupt"}, st.exp_b, ndma_intr_o);
            end
            S_BITS: begin
                check_bit({names[s], " valid"}, st.exp_a, ndma_cmd_valid_o);
                check_bit({names[s], " interrupt"}, st.exp_b, ndma_intr_o);
            end
            S_HOLD: begin
                l2c_cmd_valid_i = 1'b1;
                for (int i = 0; i < int'(st.data); i++) begin
                    @(negedge clk_i);
                    check_bit({names[s], " ready"}, 1'b0, l2c_cmd_ready_o);
                end
                l2c_cmd_valid_i = 1'b0;
            end
            default: @(negedge clk_i);
        endcase
    endtask

    // --------------------
    // Main sequence
    initial begin
        logic [31:0] rnd;
        reset_i           = 1'b1;
        hpu_id_i          = HPU;
        l2c_cmd_valid_i   = 1'b0;
        l2c_cmd_op_i      = OP_WRITE;
        l2c_cmd_lcaddr_i  = '0;
        l2c_cmd_rtaddr_i  = '0;
        l2c_cmd_size_i    = '0;
        l2c_cmd_destx_i   = '0;
        l2c_cmd_desty_i   = '0;
        ndma_cmd_ready_i  = 1'b0;
        ndma_tx_done_i    = 1'b0;
        ndma_tx_done_id_i = '0;
        ndma_rx_done_i    = 1'b0;
        ndma_rx_done_id_i = '0;
        csr_wr_en_i       = 1'b0;
        csr_waddr_i       = '0;
        csr_wdata_i       = '0;
        csr_raddr_i       = '0;
        errors            = 0;
        n_steps           = 0;

        rnd = $urandom(39);
        for (int i = 0; i < 6; i++) begin
            cmd_lc[i] = $urandom();
            cmd_rt[i] = $urandom();
            rnd       = $urandom();
            cmd_sz[i] = rnd[SIZE_W-1:0];
            cmd_dx[i] = rnd[21:20];
            cmd_dy[i] = rnd[23:22];
        end

        add_step(S_RD, "reset status", CSR_ADDR_STATUS, 32'h0, OP_WRITE, 0, 0, 0, 0);
        add_step(S_BITS, "reset outputs", 8'h0, 32'h0, OP_WRITE, 0, 0, 0, 0);
        add_sw_cmd("sw read setup", 0, OP_READ);
        add_step(S_CMD, "sw read cmd", 8'h0, cmd_id(0, 0, OP_READ, HPU), OP_READ, 0, 1, 0, 0);
        add_step(S_RD, "status after sw read", CSR_ADDR_STATUS, 32'h0, OP_WRITE, 0, 0, 0, 0);
        add_step(S_L2C, "l2c write", 8'h0, 32'h0, OP_WRITE, 1, 0, 0, 0);
        add_step(S_CMD, "l2c write cmd", 8'h0, cmd_id(1, 0, OP_WRITE, HPU), OP_WRITE, 1, 1, 0, 0);
        add_step(S_RPT, "l2c tx done", 8'h0, cmd_id(1, 0, OP_WRITE, HPU), OP_WRITE, 0, 0, 1, 0);
        add_step(S_RPT, "other node tx", 8'h0, cmd_id(1, 0, OP_WRITE, 4'h9), OP_WRITE, 0, 0, 0, 0);
        add_step(S_RPT, "sw rx done", 8'h0, cmd_id(0, 0, OP_READ, HPU), OP_WRITE, 0, 1, 0, 1);
        add_step(S_RD, "status done bit", CSR_ADDR_STATUS, 32'h0100_0000, OP_WRITE, 0, 0, 0, 0);
        add_sw_cmd("sw swap setup", 2, OP_SWAP);
        add_step(S_CMD, "sw swap cmd", 8'h0, cmd_id(0, 1, OP_SWAP, HPU), OP_SWAP, 2, 1, 0, 0);
        add_step(S_RD, "status slot 1", CSR_ADDR_STATUS, 32'h0100_0001, OP_WRITE, 0, 0, 0, 0);
        add_step(S_WR, "clear slot 0", CSR_ADDR_CTRL, 32'h0100_0003, OP_WRITE, 0, 0, 0, 0);
        add_step(S_IDLE, "clear settle", 8'h0, 32'h0, OP_WRITE, 0, 0, 0, 0);
        add_step(S_BITS, "interrupt cleared", 8'h0, 32'h0, OP_WRITE, 0, 0, 0, 0);
        add_step(S_RD, "status cleared", CSR_ADDR_STATUS, 32'h0000_0001, OP_WRITE, 0, 0, 0, 0);
        // The DMA port stays not ready until the drain steps
        add_step(S_L2C, "queue l2c", 8'h0, 32'h0, OP_WRITE, 3, 0, 0, 0);
        add_sw_cmd("queue sw setup", 4, OP_READ);
        add_step(S_POLL, "queue sw taken", CSR_ADDR_STATUS, 32'h0, OP_WRITE, 0, 0, 0, 0);
        add_step(S_BITS, "queue holds", 8'h0, 32'h0, OP_WRITE, 0, 0, 1, 0);
        add_step(S_HOLD, "l2c blocked", 8'h0, 32'd4, OP_WRITE, 0, 0, 0, 0);
        add_sw_cmd("pending sw setup", 5, OP_WRITE);
        add_step(S_RD, "status pending", CSR_ADDR_STATUS, 32'h0000_0100, OP_WRITE, 0, 0, 0, 0);
        add_step(S_CMD, "drain l2c", 8'h0, cmd_id(1, 0, OP_WRITE, HPU), OP_WRITE, 3, 1, 0, 0);
        add_step(S_CMD, "drain sw", 8'h0, cmd_id(0, 0, OP_READ, HPU), OP_READ, 4, 1, 0, 0);
        add_step(S_CMD, "drain pending", 8'h0, cmd_id(0, 2, OP_WRITE, HPU), OP_WRITE, 5, 1, 0, 0);
        add_step(S_BITS, "queue empty", 8'h0, 32'h0, OP_WRITE, 0, 0, 0, 0);

        repeat (3) @(negedge clk_i);
        reset_i = 1'b0;

        for (int s = 0; s < n_steps; s++) begin
            run_step(s);
        end

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ndma_lcarb.f
common/lcarb_pkg.sv
source/ndma_ctrl_regs.sv
source/done_slot_tracker.sv
source/cmd_source_arbiter.sv
source/cmd_queue.sv
source/ndma_lcarb.sv
verif/tb_ndma_lcarb.sv

//--- Bender.yml
package:
  name: ndma_lcarb

sources:
  - common/lcarb_pkg.sv
  - source/ndma_ctrl_regs.sv
  - source/done_slot_tracker.sv
  - source/cmd_source_arbiter.sv
  - source/cmd_queue.sv
  - source/ndma_lcarb.sv
  - target: test
    files:
      - verif/tb_ndma_lcarb.sv
